// File: lb_demo_pkg.sv
// Shared widths, page codes and register map for the diagnostic bus slave
// Imported by every design module that needs a bus or register constant
package lb_demo_pkg;

	// ====================
	// Bus and storage widths
	// ====================
	typedef logic [23:0] lb_addr_t;
	typedef logic [31:0] lb_data_t;
	typedef logic [10:0] rom_addr_t;
	typedef logic [15:0] rom_word_t;
	typedef logic [4:0]  mirror_addr_t;
	typedef logic [7:0]  duty_t;
	typedef logic [9:0]  pwm_count_t;
	typedef logic [31:0] freq_t;

	// Frequency window of 1024 clk cycles
	localparam int FREQ_REF_BITS = 10;

	// Page codes in addr[23:16]
	localparam logic [7:0] PAGE_MIRROR   = 8'h00;
	localparam logic [7:0] PAGE_RX_MAC   = 8'h03;
	localparam logic [7:0] PAGE_REG_BANK = 8'h11;

	// xxx800 to xxxfff is the ROM on any page
	localparam int ROM_SEL_BIT = 11;

	// Fixed greeting and fill words
	localparam lb_data_t HELLO_0    = "Hell";
	localparam lb_data_t HELLO_1    = "o wo";
	localparam lb_data_t HELLO_2    = "rld!";
	localparam lb_data_t HELLO_3    = "(::)";
	localparam lb_data_t UNDEF_WORD = "zzzz";
	localparam lb_data_t FILL_WORD  = 32'hdeadbeef;

	// Register bank read offsets
	localparam logic [3:0] REG_HELLO0    = 4'h0;
	localparam logic [3:0] REG_HELLO1    = 4'h1;
	localparam logic [3:0] REG_HELLO2    = 4'h2;
	localparam logic [3:0] REG_HELLO3    = 4'h3;
	localparam logic [3:0] REG_FAULTS    = 4'h4;
	localparam logic [3:0] REG_FREQ      = 4'h5;
	localparam logic [3:0] REG_TX_DONE   = 4'h6;
	localparam logic [3:0] REG_RX_STATUS = 4'h7;
	localparam logic [3:0] REG_UPTIME    = 4'h8;

	// Write offsets, page 00 only
	localparam logic [3:0] WR_LED_USER  = 4'h1;
	localparam logic [3:0] WR_LED1      = 4'h2;
	localparam logic [3:0] WR_LED2      = 4'h3;
	localparam logic [3:0] WR_FAULT_CLR = 4'h4;
	localparam logic [3:0] WR_RX_HBANK  = 4'h5;

endpackage

// File: freq_count.sv
// Frequency meter for an external clock
// Edge count of f_in over each 1024-cycle clk window, read as a status word
`timescale 1ns/10ps

module freq_count import lb_demo_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  f_in,
	output freq_t count
);

	// Gray to binary, prefix XOR from the top bit down
	function automatic freq_t gray2bin(input freq_t g);
		freq_t b;
		b[$bits(freq_t)-1] = g[$bits(freq_t)-1];
		for (int i = $bits(freq_t) - 2; i >= 0; i--) begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// ====================
	// f_in domain
	// ====================
	// Runs free from power-up, only differences are used
	freq_t bin_f = '0;
	freq_t gray_f = '0;
	freq_t bin_next;

	assign bin_next = bin_f + 1'b1;

	always_ff @(posedge f_in) begin
		bin_f  <= bin_next;
		gray_f <= bin_next ^ (bin_next >> 1);
	end

	// ====================
	// clk domain
	// ====================
	freq_t gray_s1, gray_s2;
	freq_t bin_now, bin_prev;
	logic [FREQ_REF_BITS-1:0] ref_cnt;

	// Two-flop synchronizer, one bit moves per f_in edge
	always_ff @(posedge clk) begin
		gray_s1 <= gray_f;
		gray_s2 <= gray_s1;
	end

	assign bin_now = gray2bin(gray_s2);

	// Window end on ref_cnt all ones, first result after reset is junk
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ref_cnt  <= '0;
			bin_prev <= '0;
			count    <= '0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			if (&ref_cnt) begin
				count    <= bin_now - bin_prev;
				bin_prev <= bin_now;
			end
		end
	end

	// f_in stays below twice clk, so at most two Gray steps land per cycle
	a_gray_step: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> ($countones(gray_s2 ^ $past(gray_s2)) <= 2));

endmodule

// File: config_rom.sv
// Configuration ROM, 2K words of 16 bits
// Contents come from config_rom.hex, unlisted words read zero
// Address presented on one edge, data valid after it
`timescale 1ns/10ps

module config_rom import lb_demo_pkg::*; (
	input  logic      clk,
	input  rom_addr_t address,
	output rom_word_t data
);

	localparam int ROM_WORDS = 2 ** $bits(rom_addr_t);

	// ====================
	// Storage
	// ====================
	rom_word_t rom_mem [ROM_WORDS];

	// Zero fill first, then the file overlays its words
	initial begin
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom_mem[i] = '0;
		end
		$readmemh("config_rom.hex", rom_mem);
	end

	// ====================
	// Read port
	// ====================
	// Registered output maps to block RAM
	always_ff @(posedge clk) begin
		data <= rom_mem[address];
	end

endmodule

// File: mirror_ram.sv
// Mirror RAM, 32 words of 32 bits
// Separate write and read ports on clk, read data one cycle after the address
`timescale 1ns/10ps

module mirror_ram import lb_demo_pkg::*; (
	input  logic         clk,
	input  mirror_addr_t wr_addr,
	input  lb_data_t     wr_data,
	input  logic         wr_en,
	input  mirror_addr_t rd_addr,
	output lb_data_t     rd_data
);

	localparam int MIRROR_WORDS = 2 ** $bits(mirror_addr_t);

	lb_data_t mem [MIRROR_WORDS];

	// ====================
	// Write port
	// ====================
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// ====================
	// Read port
	// ====================
	// Old data on a same-address write
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: led_pwm.sv
// PWM for two LEDs plus a period tick
// Each LED is high for 4 x duty cycles out of every 1024
`timescale 1ns/10ps

module led_pwm import lb_demo_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  duty_t duty1,
	input  duty_t duty2,
	output logic  led1,
	output logic  led2,
	output logic  tick
);

	pwm_count_t pwm_cnt;

	// ====================
	// Period counter
	// ====================
	// Carry out of the wrap is the tick
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pwm_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			{tick, pwm_cnt} <= pwm_cnt + 1'b1;
		end
	end

	// ====================
	// Comparators
	// ====================
	// Duty scaled by 4 to span the 10-bit period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= pwm_cnt < {duty1, 2'b00};
			led2 <= pwm_cnt < {duty2, 2'b00};
		end
	end

	// Zero duty means dark
	a_led1_off: assert property (@(posedge clk) disable iff (!rst_n)
		(duty1 == '0 && $past(duty1) == '0) |-> !led1);
	a_led2_off: assert property (@(posedge clk) disable iff (!rst_n)
		(duty2 == '0 && $past(duty2) == '0) |-> !led2);

endmodule

// File: lb_demo_slave.sv
// Diagnostic local-bus slave for board bring-up
// Answers reads from the greeting bank, mirror RAM, config ROM and RX MAC data
// Page 00 writes drive the LEDs, the RX half-bank select and the fault clear
`timescale 1ns/10ps

module lb_demo_slave import lb_demo_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	// Local bus
	input  lb_addr_t   addr,
	input  logic       control_strobe,
	input  logic       control_rd,
	input  lb_data_t   data_out,
	output lb_data_t   data_in,
	// Diagnostics
	input  logic       f_in,
	input  logic       xdomain_fault,
	// MAC status and data
	input  logic       tx_mac_done,
	input  rom_word_t  rx_mac_data,
	input  logic [1:0] rx_mac_buf_status,
	output logic       rx_mac_hbank,
	// Board LEDs
	output logic       led_user_mode,
	output logic       led1,
	output logic       led2
);

	// ====================
	// Bus decode
	// ====================
	logic do_rd;
	logic local_write;
	logic fault_clr;

	assign do_rd = control_strobe & control_rd;
	// Writes land only on the mirror page
	assign local_write = control_strobe & ~control_rd & (addr[23:16] == PAGE_MIRROR);
	assign fault_clr = local_write & (addr[3:0] == WR_FAULT_CLR) & data_out[0];

	// ====================
	// Status sources
	// ====================
	logic [15:0] fault_count;
	lb_data_t    uptime;
	logic        tx_mac_done_r;
	logic [1:0]  rx_mac_buf_status_r;
	freq_t       f_in_freq;
	logic        pwm_tick;

	// One cycle per fault pulse, clear wins over a same-cycle pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fault_count <= '0;
		end else if (fault_clr) begin
			fault_count <= '0;
		end else if (xdomain_fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Uptime in PWM periods
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			uptime <= '0;
		end else if (pwm_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

	// Pin MAC status into the clk domain
	always_ff @(posedge clk) begin
		tx_mac_done_r       <= tx_mac_done;
		rx_mac_buf_status_r <= rx_mac_buf_status;
	end

	freq_count u_freq_count (
		.clk   (clk),
		.rst_n (rst_n),
		.f_in  (f_in),
		.count (f_in_freq)
	);

	// ====================
	// Read stage 1
	// ====================
	rom_word_t rom_data;
	lb_data_t  mirror_data;
	lb_data_t  bank_word;
	lb_addr_t  addr_r;
	logic      rd_s1;

	// Bank word, captured only on a read strobe
	always_ff @(posedge clk) begin
		if (do_rd) begin
			case (addr[3:0])
				REG_HELLO0:    bank_word <= HELLO_0;
				REG_HELLO1:    bank_word <= HELLO_1;
				REG_HELLO2:    bank_word <= HELLO_2;
				REG_HELLO3:    bank_word <= HELLO_3;
				REG_FAULTS:    bank_word <= lb_data_t'(fault_count);
				REG_FREQ:      bank_word <= f_in_freq;
				REG_TX_DONE:   bank_word <= lb_data_t'(tx_mac_done_r);
				REG_RX_STATUS: bank_word <= lb_data_t'(rx_mac_buf_status_r);
				REG_UPTIME:    bank_word <= uptime;
				default:       bank_word <= UNDEF_WORD;
			endcase
		end
	end

	// Address held for the stage 2 decode
	always_ff @(posedge clk) begin
		addr_r <= addr;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_s1 <= 1'b0;
		end else begin
			rd_s1 <= do_rd;
		end
	end

	// ROM and mirror read every cycle, result ready for stage 2
	config_rom u_config_rom (
		.clk     (clk),
		.address (addr[10:0]),
		.data    (rom_data)
	);

	mirror_ram u_mirror_ram (
		.clk     (clk),
		.wr_addr (addr[4:0]),
		.wr_data (data_out),
		.wr_en   (local_write),
		.rd_addr (addr[4:0]),
		.rd_data (mirror_data)
	);

	// ====================
	// Read stage 2
	// ====================
	// ROM bit beats the page code
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (rd_s1) begin
			if (addr_r[ROM_SEL_BIT]) begin
				data_in <= lb_data_t'(rom_data);
			end else if (addr_r[23:16] == PAGE_MIRROR) begin
				data_in <= mirror_data;
			end else if (addr_r[23:16] == PAGE_RX_MAC) begin
				data_in <= lb_data_t'(rx_mac_data);
			end else if (addr_r[23:16] == PAGE_REG_BANK) begin
				data_in <= bank_word;
			end else begin
				data_in <= FILL_WORD;
			end
		end
	end

	// ====================
	// Write registers
	// ====================
	duty_t led1_duty;
	duty_t led2_duty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_user_mode <= 1'b0;
			led1_duty     <= '0;
			led2_duty     <= '0;
			rx_mac_hbank  <= 1'b1;
		end else if (local_write) begin
			case (addr[3:0])
				WR_LED_USER: led_user_mode <= data_out[0];
				WR_LED1:     led1_duty     <= data_out[7:0];
				WR_LED2:     led2_duty     <= data_out[7:0];
				WR_RX_HBANK: rx_mac_hbank  <= data_out[0];
				default:     ;
			endcase
		end
	end

	// Dimmed LEDs, period tick feeds the uptime counter
	led_pwm u_led_pwm (
		.clk   (clk),
		.rst_n (rst_n),
		.duty1 (led1_duty),
		.duty2 (led2_duty),
		.led1  (led1),
		.led2  (led2),
		.tick  (pwm_tick)
	);

	// Reset leaves the upper RX half-bank selected
	a_hbank_reset: assert property (@(posedge clk) !rst_n |=> rx_mac_hbank);

	// Read data moves only after a stage 2 read or a reset
	a_data_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(data_in) |-> ($past(rd_s1) || !$past(rst_n)));

endmodule

// File: tb_lb_demo.sv
// Directed testbench for the diagnostic local-bus slave
// Drives bus reads and writes, MAC status, fault pulses and an external clock
// Run from the project root so the ROM data file is found
`timescale 1ns/10ps

module tb_lb_demo import lb_demo_pkg::*; ();

	// ====================
	// Clocks, DUT and timeout
	// ====================
	localparam int CLK_HALF = 50;
	// 70 ns period on f_in
	localparam int FIN_HALF = 35;
	// Tests need about 11000 cycles, the rest is margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int SEED = 32'h6c4;

	logic clk, rst_n, f_in;
	lb_addr_t addr;
	logic control_strobe, control_rd;
	lb_data_t data_out, data_in;
	logic xdomain_fault, tx_mac_done;
	rom_word_t rx_mac_data;
	logic [1:0] rx_mac_buf_status;
	logic rx_mac_hbank, led_user_mode, led1, led2;
	int cycle_count = 0;
	duty_t pwm_duties [3] = '{8'd0, 8'd64, 8'd255};

	lb_demo_slave dut (
		.clk (clk), .rst_n (rst_n),
		.addr (addr), .control_strobe (control_strobe), .control_rd (control_rd),
		.data_out (data_out), .data_in (data_in),
		.f_in (f_in), .xdomain_fault (xdomain_fault),
		.tx_mac_done (tx_mac_done), .rx_mac_data (rx_mac_data),
		.rx_mac_buf_status (rx_mac_buf_status), .rx_mac_hbank (rx_mac_hbank),
		.led_user_mode (led_user_mode), .led1 (led1), .led2 (led2)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// Unrelated to clk on purpose
	initial begin
		f_in = 1'b0;
		forever #FIN_HALF f_in = ~f_in;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("Timeout, tests still running after %0d cycles", cycle_count));
	end

	// ====================
	// Compare and bus tasks
	// ====================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_data(input string name, input lb_data_t got, input lb_data_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %0t %s got %b expected %b", $time, name, got, exp));
	endtask

	// Inclusive bounds
	task automatic check_range(input string name, input freq_t got, input freq_t lo,
			input freq_t hi);
		if ($isunknown(got) || got < lo || got > hi)
			abort_run($sformatf("[ERROR] %0t %s got %0d expected %0d to %0d",
				$time, name, got, lo, hi));
	endtask

	// One-cycle write strobe, the write lands on the following edge
	task automatic bus_write(input lb_addr_t a, input lb_data_t d);
		@(posedge clk);
		addr <= a;
		data_out <= d;
		control_rd <= 1'b0;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
	endtask

	// Edge N samples the strobe, data_in settles after N+1
	task automatic bus_read(input lb_addr_t a, output lb_data_t d);
		@(posedge clk);
		addr <= a;
		control_rd <= 1'b1;
		control_strobe <= 1'b1;
		@(posedge clk);
		control_strobe <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = data_in;
	endtask

	task automatic read_expect(input lb_addr_t a, input lb_data_t exp);
		lb_data_t d;
		bus_read(a, d);
		check_data($sformatf("data_in at %06h", a), d, exp);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic reset_and_bank;
		@(negedge clk);
		check_bit("led_user_mode", led_user_mode, 1'b0);
		check_bit("led1", led1, 1'b0);
		check_bit("led2", led2, 1'b0);
		check_bit("rx_mac_hbank", rx_mac_hbank, 1'b1);
		check_data("data_in", data_in, '0);
		read_expect(24'h110000, HELLO_0);
		read_expect(24'h110001, HELLO_1);
		read_expect(24'h110002, HELLO_2);
		read_expect(24'h110003, HELLO_3);
		read_expect(24'h110009, UNDEF_WORD);
		// Unmapped pages, trace pages included
		read_expect(24'h010000, FILL_WORD);
		read_expect(24'h020000, FILL_WORD);
		read_expect(24'h200000, FILL_WORD);
	endtask

	task automatic mirror_ram_echo;
		lb_data_t mirror_ref [32];
		for (int k = 0; k < 32; k++) begin
			mirror_ref[k] = $urandom;
			bus_write(lb_addr_t'(k), mirror_ref[k]);
		end
		for (int k = 0; k < 32; k++)
			read_expect(lb_addr_t'(k), mirror_ref[k]);
		// Strobe on every cycle, word k shows after edge k+2
		for (int i = 0; i < 34; i++) begin
			@(posedge clk);
			addr <= lb_addr_t'(i % 32);
			control_rd <= 1'b1;
			control_strobe <= (i < 32);
			@(negedge clk);
			if (i >= 2)
				check_data($sformatf("data_in burst %0d", i - 2), data_in, mirror_ref[i - 2]);
		end
	endtask

	task automatic rom_and_rx_pages;
		rom_word_t rom_ref [32];
		rom_word_t rx_val;
		$readmemh("config_rom.hex", rom_ref);
		for (int k = 0; k < 32; k++)
			read_expect(lb_addr_t'(24'h000800 + k), lb_data_t'(rom_ref[k]));
		read_expect(24'h000900, '0);
		rx_val = rom_word_t'($urandom);
		@(posedge clk);
		rx_mac_data <= rx_val;
		read_expect(24'h030000, lb_data_t'(rx_val));
	endtask

	task automatic status_registers;
		int n;
		bus_write(24'h000004, 32'h1);
		n = $urandom_range(40, 5);
		@(posedge clk);
		xdomain_fault <= 1'b1;
		repeat (n) @(posedge clk);
		xdomain_fault <= 1'b0;
		read_expect(24'h110004, lb_data_t'(n));
		bus_write(24'h000004, 32'h1);
		read_expect(24'h110004, '0);
		// MAC status, two patterns
		@(posedge clk);
		tx_mac_done <= 1'b1;
		rx_mac_buf_status <= 2'b10;
		read_expect(24'h110006, 32'h1);
		read_expect(24'h110007, 32'h2);
		@(posedge clk);
		tx_mac_done <= 1'b0;
		rx_mac_buf_status <= 2'b01;
		read_expect(24'h110006, 32'h0);
		read_expect(24'h110007, 32'h1);
		// Upper data bits are ignored by the 1-bit registers
		bus_write(24'h000005, 32'hffff_fffe);
		@(negedge clk);
		check_bit("rx_mac_hbank", rx_mac_hbank, 1'b0);
		bus_write(24'h000005, 32'h1);
		@(negedge clk);
		check_bit("rx_mac_hbank", rx_mac_hbank, 1'b1);
		bus_write(24'h000001, 32'h1);
		@(negedge clk);
		check_bit("led_user_mode", led_user_mode, 1'b1);
		bus_write(24'h000001, 32'hffff_fffe);
		@(negedge clk);
		check_bit("led_user_mode", led_user_mode, 1'b0);
	endtask

	task automatic pwm_and_uptime;
		int n1, n2, e1, e2;
		lb_data_t u0, u1;
		for (int i = 0; i < 3; i++) begin
			e1 = 4 * int'(pwm_duties[i]);
			e2 = 4 * (255 - int'(pwm_duties[i]));
			bus_write(24'h000002, lb_data_t'(pwm_duties[i]));
			bus_write(24'h000003, lb_data_t'(8'd255 - pwm_duties[i]));
			// Duty register, then the registered compare
			repeat (4) @(posedge clk);
			n1 = 0;
			n2 = 0;
			repeat (1024) begin
				@(negedge clk);
				if (led1) n1++;
				if (led2) n2++;
			end
			check_range("led1 high cycles", freq_t'(n1), freq_t'(e1), freq_t'(e1));
			check_range("led2 high cycles", freq_t'(n2), freq_t'(e2), freq_t'(e2));
		end
		bus_read(24'h110008, u0);
		repeat (3072) @(posedge clk);
		bus_read(24'h110008, u1);
		check_range("uptime delta", u1 - u0, 32'd2, 32'd4);
	endtask

	// 102400 ns window over a 70 ns period
	task automatic freq_measure;
		lb_data_t f;
		repeat (3 * 1024) @(posedge clk);
		bus_read(24'h110005, f);
		check_range("f_in count", f, 32'd1461, 32'd1465);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		addr = '0;
		control_strobe = 1'b0;
		control_rd = 1'b0;
		data_out = '0;
		xdomain_fault = 1'b0;
		tx_mac_done = 1'b0;
		rx_mac_data = '0;
		rx_mac_buf_status = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		reset_and_bank();
		mirror_ram_echo();
		rom_and_rx_pages();
		status_registers();
		pwm_and_uptime();
		freq_measure();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: config_rom.hex
// Config ROM image, one 16-bit hex word per line, addresses 000 to 01f
// Words past 01f are not listed and read as zero
4c42
0001
0203
a5a5
5a5a
1234
8000
00ff
ff00
0f0f
f0f0
3c3c
c3c3
0800
0400
0200
0100
0080
0040
0020
0010
0008
0004
0002
dead
beef
cafe
f00d
1357
2468
7e7e
ffff

// File: lb_demo.f
lb_demo_pkg.sv
freq_count.sv
config_rom.sv
mirror_ram.sv
led_pwm.sv
lb_demo_slave.sv
tb_lb_demo.sv

// File: Makefile
# Verilator build and run of the local-bus slave testbench
# A failing check ends the run through $fatal, which gives a nonzero exit status

sim:
	verilator --binary --timing --assert -Wno-fatal -f lb_demo.f \
		--top-module tb_lb_demo -o sim_lb_demo
	./obj_dir/sim_lb_demo

clean:
	rm -rf obj_dir

.PHONY: sim clean
